// ==== rtl/i2c_init_pkg.sv ====
// ==================================================
// i2c init package
// table word layout, command encodings, output
// payload types and sequencer states
// ==================================================

`default_nettype none

package i2c_init_pkg;

  // table word is 9 bits wide
  localparam int WORD_W = 9;
  typedef logic [WORD_W-1:0] init_word_t;

  typedef logic [6:0] dev_addr_t;
  typedef logic [7:0] data_byte_t;

  // command stream payload, address plus request flags
  typedef struct packed {
    dev_addr_t addr;
    logic      start;
    logic      write;
    logic      stop;
  } i2c_cmd_t;

  // prefix positions
  // top bit set means a data byte
  localparam int DATA_BIT = 8;
  // bits [8:7] == 01 mean start write to address
  localparam int PREFIX_LSB = 7;
  localparam logic [1:0] ADDR_PREFIX = 2'b01;

  // fixed command words
  localparam init_word_t CMD_END        = 9'd0;
  localparam init_word_t CMD_EXIT_MULTI = 9'd1;
  localparam init_word_t CMD_WRITE_CUR  = 9'd3;
  localparam init_word_t CMD_ADDR_BLOCK = 9'd8;
  localparam init_word_t CMD_DATA_BLOCK = 9'd9;
  localparam init_word_t CMD_SEND_STOP  = 9'b001000001;

  typedef enum logic [2:0] {
    IDLE,
    RUN,
    FIND_ADDR_BLOCK,
    NEXT_ADDR,
    DATA_BLOCK
  } seq_state_t;

  // table building helpers
  function automatic init_word_t data_word(data_byte_t b);
    return {1'b1, b};
  endfunction

  function automatic init_word_t addr_word(dev_addr_t a);
    return {ADDR_PREFIX, a};
  endfunction

endpackage

`default_nettype wire

// ==== rtl/i2c_init_top.sv ====
// ==================================================
// i2c_init_top
// i2c bus init sequencer, rom fetch, table walker
// and command/data output slots
// ==================================================

`timescale 1ns/10ps
`default_nettype none

module i2c_init_top #(
  parameter int INIT_LEN = 22
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  output i2c_init_pkg::i2c_cmd_t   cmd,
  output logic                     cmd_valid,
  input  logic                     cmd_ready,
  output i2c_init_pkg::data_byte_t data,
  output logic                     data_valid,
  input  logic                     data_ready,
  output logic                     busy
);

  import i2c_init_pkg::*;

  localparam int AW = $clog2(INIT_LEN);

  logic [AW-1:0] rd_addr;
  init_word_t    word;
  logic          cmd_load, data_load;
  i2c_cmd_t      cmd_next;
  data_byte_t    data_next;
  logic          hold;

  // sequencer waits for both slots to drain
  assign hold = cmd_valid | data_valid;

  init_rom #(.INIT_LEN(INIT_LEN)) u_rom (
    .clk     (clk),
    .rd_addr (rd_addr),
    .word    (word)
  );

  init_sequencer #(.INIT_LEN(INIT_LEN)) u_seq (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .word      (word),
    .hold      (hold),
    .rd_addr   (rd_addr),
    .cmd_load  (cmd_load),
    .cmd_next  (cmd_next),
    .data_load (data_load),
    .data_next (data_next),
    .busy      (busy)
  );

  // command stream
  out_slot #(.payload_t(i2c_cmd_t)) u_cmd_slot (
    .clk   (clk),
    .rst   (rst),
    .load  (cmd_load),
    .din   (cmd_next),
    .ready (cmd_ready),
    .dout  (cmd),
    .valid (cmd_valid)
  );

  // data stream
  out_slot #(.payload_t(data_byte_t)) u_data_slot (
    .clk   (clk),
    .rst   (rst),
    .load  (data_load),
    .din   (data_next),
    .ready (data_ready),
    .dout  (data),
    .valid (data_valid)
  );

endmodule

`default_nettype wire

// ==== rtl/init_rom.sv ====
// ==================================================
// init_rom
// registered command table, one cycle fetch
// holds the single and multi device demo sequence
// ==================================================

`timescale 1ns/10ps
`default_nettype none

module init_rom #(
  parameter int INIT_LEN = 22,
  localparam int AW = $clog2(INIT_LEN)
) (
  input  logic                    clk,
  input  logic [AW-1:0]           rd_addr,
  output i2c_init_pkg::init_word_t word
);

  import i2c_init_pkg::*;

  always_ff @(posedge clk) begin
    case (int'(rd_addr))
      // single device, write 0x11223344 to reg 0x0004 at 0x50
      0:  word <= addr_word(7'h50);
      1:  word <= data_word(8'h00);
      2:  word <= data_word(8'h04);
      3:  word <= data_word(8'h11);
      4:  word <= data_word(8'h22);
      5:  word <= data_word(8'h33);
      6:  word <= data_word(8'h44);
      // same write as a data block
      7:  word <= CMD_DATA_BLOCK;
      8:  word <= CMD_WRITE_CUR;
      9:  word <= data_word(8'h00);
      10: word <= data_word(8'h04);
      11: word <= data_word(8'h11);
      12: word <= data_word(8'h22);
      13: word <= data_word(8'h33);
      14: word <= data_word(8'h44);
      // address list for the block
      15: word <= CMD_ADDR_BLOCK;
      16: word <= addr_word(7'h50);
      17: word <= addr_word(7'h51);
      18: word <= addr_word(7'h52);
      19: word <= addr_word(7'h53);
      20: word <= CMD_EXIT_MULTI;
      // end of table, also past the last entry
      default: word <= CMD_END;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/init_sequencer.sv ====
// ==================================================
// init_sequencer
// walks the command table, single and multi device
// modes, drives the command and data output slots
// ==================================================

`timescale 1ns/10ps
`default_nettype none

module init_sequencer #(
  parameter int INIT_LEN = 22,
  localparam int AW = $clog2(INIT_LEN)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  i2c_init_pkg::init_word_t word,
  input  logic                     hold,
  output logic [AW-1:0]            rd_addr,
  output logic                     cmd_load,
  output i2c_init_pkg::i2c_cmd_t   cmd_next,
  output logic                     data_load,
  output i2c_init_pkg::data_byte_t data_next,
  output logic                     busy
);

  import i2c_init_pkg::*;

  seq_state_t state, state_n;

  // table pointer, saved block pointers
  logic [AW-1:0] ptr, ptr_n, ptr_inc;
  logic [AW-1:0] addr_ptr, addr_ptr_n;
  logic [AW-1:0] data_ptr, data_ptr_n;

  // address from the address block
  dev_addr_t cur_addr, cur_addr_n;
  // address and pending start for the next write command
  dev_addr_t out_addr, out_addr_n;
  logic      start_pend, start_pend_n;

  logic start_flag, start_flag_n;

  // word decode
  logic is_data, is_addr;
  logic emit_write, emit_stop;

  assign ptr_inc = ptr + 1'b1;
  assign is_data = word[DATA_BIT];
  assign is_addr = word[DATA_BIT:PREFIX_LSB] == ADDR_PREFIX;
  assign rd_addr = ptr_n;

  always_comb begin
    state_n      = state;
    ptr_n        = ptr;
    addr_ptr_n   = addr_ptr;
    data_ptr_n   = data_ptr;
    cur_addr_n   = cur_addr;
    out_addr_n   = out_addr;
    start_pend_n = start_pend;
    start_flag_n = start_flag;
    emit_write   = 1'b0;
    emit_stop    = 1'b0;

    // frozen until both slots drain
    if (!hold) begin
      // most words just step to the next entry
      if (state != IDLE) ptr_n = ptr_inc;

      case (state)
        IDLE: begin
          // only a fresh start request
          if (start && !start_flag) begin
            ptr_n        = '0;
            start_flag_n = 1'b1;
            state_n      = RUN;
          end
        end
        RUN: begin
          if (is_data) begin
            emit_write = 1'b1;
          end else if (is_addr) begin
            out_addr_n   = word[PREFIX_LSB-1:0];
            start_pend_n = 1'b1;
          end else if (word == CMD_SEND_STOP) begin
            emit_stop = 1'b1;
          end else if (word == CMD_DATA_BLOCK) begin
            data_ptr_n = ptr_inc;
            state_n    = FIND_ADDR_BLOCK;
          end else if (word == CMD_END) begin
            emit_stop = 1'b1;
            ptr_n     = ptr;
            state_n   = IDLE;
          end
        end
        FIND_ADDR_BLOCK: begin
          // skip over the data block body
          if (word == CMD_ADDR_BLOCK) begin
            addr_ptr_n = ptr_inc;
            state_n    = NEXT_ADDR;
          end else if (word == CMD_DATA_BLOCK) begin
            data_ptr_n = ptr_inc;
          end else if (word == CMD_EXIT_MULTI) begin
            state_n = RUN;
          end else if (word == CMD_END) begin
            emit_stop = 1'b1;
            ptr_n     = ptr;
            state_n   = IDLE;
          end
        end
        NEXT_ADDR: begin
          if (is_addr) begin
            // take address, replay the data block
            cur_addr_n = word[PREFIX_LSB-1:0];
            addr_ptr_n = ptr_inc;
            ptr_n      = data_ptr;
            state_n    = DATA_BLOCK;
          end else if (word == CMD_DATA_BLOCK) begin
            data_ptr_n = ptr_inc;
            state_n    = FIND_ADDR_BLOCK;
          end else if (word == CMD_EXIT_MULTI) begin
            state_n = RUN;
          end else if (word == CMD_END) begin
            emit_stop = 1'b1;
            ptr_n     = ptr;
            state_n   = IDLE;
          end
        end
        DATA_BLOCK: begin
          if (is_data) begin
            emit_write = 1'b1;
          end else if (is_addr) begin
            out_addr_n   = word[PREFIX_LSB-1:0];
            start_pend_n = 1'b1;
          end else if (word == CMD_WRITE_CUR) begin
            out_addr_n   = cur_addr;
            start_pend_n = 1'b1;
          end else if (word == CMD_SEND_STOP) begin
            emit_stop = 1'b1;
          end else if (word == CMD_DATA_BLOCK) begin
            data_ptr_n = ptr_inc;
            state_n    = FIND_ADDR_BLOCK;
          end else if (word == CMD_ADDR_BLOCK) begin
            // end of block body, go fetch next address
            ptr_n   = addr_ptr;
            state_n = NEXT_ADDR;
          end else if (word == CMD_EXIT_MULTI) begin
            state_n = RUN;
          end else if (word == CMD_END) begin
            emit_stop = 1'b1;
            ptr_n     = ptr;
            state_n   = IDLE;
          end
        end
        default: state_n = IDLE;
      endcase
    end

    // output slot loads
    cmd_load       = emit_write | emit_stop;
    data_load      = emit_write;
    cmd_next.addr  = out_addr;
    cmd_next.start = emit_write & start_pend;
    cmd_next.write = emit_write;
    cmd_next.stop  = emit_stop;
    data_next      = word[DATA_BIT-1:0];
    // start goes out with the first command after it
    if (emit_write || emit_stop) start_pend_n = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      ptr        <= '0;
      addr_ptr   <= '0;
      data_ptr   <= '0;
      cur_addr   <= '0;
      out_addr   <= '0;
      start_pend <= 1'b0;
      start_flag <= 1'b0;
      busy       <= 1'b0;
    end else begin
      state      <= state_n;
      ptr        <= ptr_n;
      addr_ptr   <= addr_ptr_n;
      data_ptr   <= data_ptr_n;
      cur_addr   <= cur_addr_n;
      out_addr   <= out_addr_n;
      start_pend <= start_pend_n;
      // flag drops only once start goes low
      start_flag <= start & start_flag_n;
      busy       <= state != IDLE;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/out_slot.sv ====
// ==================================================
// out_slot
// one entry output register with valid/ready
// ==================================================

`timescale 1ns/10ps
`default_nettype none

module out_slot #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     load,
  input  payload_t din,
  input  logic     ready,
  output payload_t dout,
  output logic     valid
);

  // loads only arrive while empty
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (ready) begin
      // transfer empties the slot
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) dout <= din;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb | grep "Simulation passed" \
  || { echo "run failed"; exit 1; }

// ==== tb.f ====
rtl/i2c_init_pkg.sv
rtl/init_rom.sv
rtl/init_sequencer.sv
rtl/out_slot.sv
rtl/i2c_init_top.sv
test/tb_clock.sv
test/i2c_init_props.sv
test/tb_top.sv

// ==== test/i2c_init_patterns.txt ====
// 1xxx command {addr[6:0],start,write,stop}, 2xxx data byte
// 30nn control: 00 ready high, 01 random stalls, 02 held start, 03 reset mid-run
3000 3001 3002 3003
// single device write at 0x50
1286 1282 1282 1282 1282 1282
2000 2004 2011 2022 2033 2044
// data block at 0x50
1286 1282 1282 1282 1282 1282
2000 2004 2011 2022 2033 2044
// data block at 0x51
128E 128A 128A 128A 128A 128A
2000 2004 2011 2022 2033 2044
// data block at 0x52
1296 1292 1292 1292 1292 1292
2000 2004 2011 2022 2033 2044
// data block at 0x53
129E 129A 129A 129A 129A 129A
2000 2004 2011 2022 2033 2044
// final stop after exit, last address kept
1299

// ==== test/i2c_init_props.sv ====
// ==================================================
// i2c_init_props
// handshake and reset checks, bound to the output
// slots and to the init top level
// ==================================================

`timescale 1ns/10ps
`default_nettype none

module i2c_init_props #(
  parameter int W = 8
) (
  input logic         clk,
  input logic         rst,
  input logic         load,
  input logic         valid,
  input logic         ready,
  input logic [W-1:0] payload,
  input logic         busy
);

  // a held valid keeps its payload until the transfer
  hold_stable: assert property (@(posedge clk) disable iff (rst)
    valid && !ready |=> valid && $stable(payload))
    else $error("valid dropped or payload changed before transfer");

  // outputs quiet right after reset
  reset_quiet: assert property (@(posedge clk) rst |=> !valid && !busy)
    else $error("valid or busy high after reset");

  // slot only loaded while empty
  no_overrun: assert property (@(posedge clk) disable iff (rst) load |-> !valid)
    else $error("load while slot full");

endmodule

bind out_slot i2c_init_props #(.W($bits(dout))) u_slot_props (
  .clk     (clk),
  .rst     (rst),
  .load    (load),
  .valid   (valid),
  .ready   (ready),
  .payload (dout),
  .busy    (1'b0)
);

bind i2c_init_top i2c_init_props #(.W($bits(cmd))) u_top_props (
  .clk     (clk),
  .rst     (rst),
  .load    (cmd_load),
  .valid   (cmd_valid),
  .ready   (cmd_ready),
  .payload (cmd),
  .busy    (busy)
);

`default_nettype wire

// ==== test/tb_clock.sv ====
// ==================================================
// tb_clock
// free running testbench clock, 4 ns period
// ==================================================

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int HALF_NS = 2
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
// ==================================================
// tb_top
// runs the init table under several ready modes,
// checks both streams against the pattern file
// ==================================================

`timescale 1ns/10ps
`default_nettype none

module tb_top;

  import i2c_init_pkg::*;

  logic       clk;
  logic       rst;
  logic       start;
  logic       cmd_ready;
  logic       data_ready;
  i2c_cmd_t   cmd;
  logic       cmd_valid;
  data_byte_t data;
  logic       data_valid;
  logic       busy;

  // pattern words, top nibble gives the kind
  logic [15:0] pat_mem [0:127];
  logic [15:0] exp_cmd [$];
  logic [15:0] exp_data [$];
  logic [7:0]  ctrl [$];

  int ci;
  int di;
  bit stall;
  int limit_cycles;

  tb_clock u_clk (.clk(clk));

  i2c_init_top #(.INIT_LEN(22)) UUT (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .data       (data),
    .data_valid (data_valid),
    .data_ready (data_ready),
    .busy       (busy)
  );

  task automatic fail_now(input string what);
    $display("%s at %0t", what, $time);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // random or constant ready
  always @(posedge clk) begin
    cmd_ready  <= stall ? 1'($urandom_range(0, 1)) : 1'b1;
    data_ready <= stall ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  // transfer monitor, one index per stream
  always @(posedge clk) begin
    if (!rst && cmd_valid && cmd_ready) begin
      if (ci >= exp_cmd.size()) begin
        fail_now("unexpected command transfer past the end of the list");
      end else begin
        check("cmd", exp_cmd[ci], 16'(cmd));
        ci++;
      end
    end
    if (!rst && data_valid && data_ready) begin
      if (di >= exp_data.size()) begin
        fail_now("unexpected data transfer past the end of the list");
      end else begin
        check("data", exp_data[di], 16'(data));
        di++;
      end
    end
  end

  // one pass through the table, start optionally left high
  task automatic run_list(input bit held);
    ci = 0;
    di = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    if (!held) start <= 1'b0;
    while (ci == 0) @(posedge clk);
    check("busy", 16'h1, 16'(busy));
    while (ci < exp_cmd.size() || di < exp_data.size()) @(posedge clk);
    repeat (3) @(posedge clk);
    check("busy", 16'h0, 16'(busy));
  endtask

  task automatic reset_mid_run();
    ci = 0;
    di = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (ci < 10) @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check("cmd_valid", 16'h0, 16'(cmd_valid));
    check("data_valid", 16'h0, 16'(data_valid));
    run_list(1'b0);
  endtask

  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    cmd_ready  = 1'b0;
    data_ready = 1'b0;
    stall      = 1'b0;
    ci         = 0;
    di         = 0;
    limit_cycles = 0;
    void'($urandom(55302));
    foreach (pat_mem[i]) pat_mem[i] = 16'h0;
    $readmemh("test/i2c_init_patterns.txt", pat_mem);
    foreach (pat_mem[i]) begin
      case (pat_mem[i][15:12])
        4'h1: exp_cmd.push_back(16'(pat_mem[i][9:0]));
        4'h2: exp_data.push_back(16'(pat_mem[i][7:0]));
        4'h3: ctrl.push_back(pat_mem[i][7:0]);
        default: ;
      endcase
    end
    if (exp_cmd.size() == 0 || ctrl.size() == 0) begin
      fail_now("pattern file missing or empty");
    end else begin
      // two passes per control plus the held start wait
      limit_cycles = (exp_cmd.size() + exp_data.size()) * ctrl.size() * 2 * 64 + 2000;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      foreach (ctrl[k]) begin
        stall <= ctrl[k] != 8'h00;
        case (ctrl[k])
          8'h00, 8'h01: run_list(1'b0);
          8'h02: begin
            run_list(1'b1);
            // held start must leave the sequencer idle
            repeat (200) begin
              @(posedge clk);
              check("busy", 16'h0, 16'(busy));
              check("cmd_valid", 16'h0, 16'(cmd_valid));
            end
            start <= 1'b0;
            run_list(1'b0);
          end
          default: reset_mid_run();
        endcase
      end
      $display("Simulation passed");
      $finish;
    end
  end

  // watchdog sized from the pattern list
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * 4);
    fail_now("timeout, sequence did not complete in time");
  end

endmodule

`default_nettype wire
